// File: bench/cv_ctrl_stim.txt
# Test vectors, one per clock, all values hex: name ps2_key joy0 joy1 swap sel_keypad_n sel_joy_n
# Then the expected port lines {ctrl[3:0], p6} of player 0 and player 1
# Reset state
reset_idle          000 00000000 00000000 0 3 3 1F 1F
reset_keypad        000 00000000 00000000 0 0 3 1F 1F
# Keypad priority and fire 2
kp_digit3_7         000 00008800 00000000 0 0 3 0D 1F
kp_star             000 00000040 00000000 0 0 3 15 1F
kp_purple           000 00000000 00040000 0 0 3 1F 09
kp_blue             000 00080000 00000000 0 0 3 05 1F
kp_fire2            000 00000020 00000000 0 0 3 1E 1F
kp_fire2_joysel     000 00000020 00000000 0 3 0 1F 1F
# Joystick select and both selects
js_up_right         000 00000009 00000000 0 3 0 0D 1F
js_fire1            000 00000000 00000010 0 3 0 1F 1E
both_sel            000 00000128 00000000 0 0 0 06 1F
# Swap
swap_keypad         000 00000200 00080000 1 0 3 05 1D
swap_joy            000 00000002 00000010 1 3 0 1E 1B
# Keyboard
kbd_num5_press      673 00000000 00000000 0 0 3 13 13
kbd_stale_release   473 00000000 00000000 0 0 3 13 13
kbd_num5_release    073 00000000 00000000 0 0 3 1F 1F
kbd_row8_press      63E 00000000 00000000 0 0 3 11 11
kbd_row8_release    03E 00000000 00000000 0 0 3 1F 1F
kbd_shift_press     612 00000000 00000000 0 0 3 1F 1F
kbd_shift8_press    23E 00000000 00000000 0 0 3 15 15
kbd_shift8_release  43E 00000000 00000000 0 0 3 1F 1F
kbd_shift3_press    226 00000000 00000000 0 0 3 0B 0B
kbd_shift3_release  426 00000000 00000000 0 0 3 1F 1F
kbd_shift_release   012 00000000 00000000 0 0 3 1F 1F
kbd_star_ext        77C 00000000 00000000 0 0 3 15 15
kbd_merge_joy       77C 00020000 00000000 0 0 3 17 15
kbd_star_release    07C 00000000 00000000 0 0 3 1F 1F

// File: bench/cv_ctrl_tb.sv
// Run from the project root so bench/cv_ctrl_stim.txt is found; one vector per clock
module cv_ctrl_tb;
        import cv_ctrl_pkg::*;

        localparam int MAX_VECTORS = 64;
        localparam int NAME_BITS   = 8 * 24;
        localparam int LINE_BITS   = 8 * 160;

        logic                   clk_sys;
        logic                   reset_i;
        ps2_event_t             ps2_key_i;
        joy_word_t              joy0_i;
        joy_word_t              joy1_i;
        logic                   swap_i;
        logic [NUM_PLAYERS-1:0] sel_keypad_n_i;
        logic [NUM_PLAYERS-1:0] sel_joy_n_i;
        port_lines_t            port_o [NUM_PLAYERS];

        // Vector table filled from the stim file
        logic [NAME_BITS-1:0] vec_name   [MAX_VECTORS];
        logic [10:0]          vec_ps2    [MAX_VECTORS];
        logic [31:0]          vec_joy0   [MAX_VECTORS];
        logic [31:0]          vec_joy1   [MAX_VECTORS];
        logic                 vec_swap   [MAX_VECTORS];
        logic [1:0]           vec_sel_kp [MAX_VECTORS];
        logic [1:0]           vec_sel_js [MAX_VECTORS];
        logic [4:0]           vec_exp0   [MAX_VECTORS];
        logic [4:0]           vec_exp1   [MAX_VECTORS];

        int num_vectors = 0;
        int pass_count  = 0;
        int fail_count  = 0;
        int cycle_count = 0;
        int cycle_limit = 20;

        cv_ctrl_top cv_ctrl_top_inst (
                .clk_sys        (clk_sys),
                .reset_i        (reset_i),
                .ps2_key_i      (ps2_key_i),
                .joy0_i         (joy0_i),
                .joy1_i         (joy1_i),
                .swap_i         (swap_i),
                .sel_keypad_n_i (sel_keypad_n_i),
                .sel_joy_n_i    (sel_joy_n_i),
                .port_o         (port_o)
        );

        // ==================================================================
        // Clock and timeout
        // ==================================================================

        always #4 clk_sys = ~clk_sys;

        always @(posedge clk_sys) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= cycle_limit) begin
                        $display("ERROR: run did not finish within %0d cycles", cycle_limit);
                        $display("Simulation finished: FAIL");
                        $finish;
                end
        end

        // ==================================================================
        // Helpers
        // ==================================================================

        // Comment lines start with a lone # token, blank lines are skipped
        task automatic load_vectors(output logic ok);
                int                   fd;
                int                   count;
                int                   line_num;
                logic [LINE_BITS-1:0] line;
                logic [NAME_BITS-1:0] name;
                logic [10:0]          ps2;
                logic [31:0]          joy0;
                logic [31:0]          joy1;
                logic                 swap;
                logic [1:0]           sel_kp;
                logic [1:0]           sel_js;
                logic [4:0]           exp0;
                logic [4:0]           exp1;
                ok       = 1'b1;
                line_num = 0;
                fd = $fopen("bench/cv_ctrl_stim.txt", "r");
                if (fd == 0) begin
                        $display("ERROR: cannot open stimulus file bench/cv_ctrl_stim.txt");
                        ok = 1'b0;
                end else begin
                        while (ok && !$feof(fd)) begin
                                line  = '0;
                                name  = '0;
                                count = 0;
                                if ($fgets(line, fd) > 0) begin
                                        line_num = line_num + 1;
                                        count = $sscanf(line, "%s %h %h %h %h %h %h %h %h",
                                                name, ps2, joy0, joy1, swap,
                                                sel_kp, sel_js, exp0, exp1);
                                end
                                if (count <= 0) begin
                                        // Blank line
                                end else if (name[7:0] == 8'h23 && name[NAME_BITS-1:8] == '0) begin
                                        // Comment line
                                end else if (count != 9) begin
                                        $display("ERROR: malformed line %0d in stimulus file",
                                                 line_num);
                                        ok = 1'b0;
                                end else if (num_vectors >= MAX_VECTORS) begin
                                        $display("ERROR: more than %0d vectors in stimulus file",
                                                 MAX_VECTORS);
                                        ok = 1'b0;
                                end else begin
                                        vec_name[num_vectors]   = name;
                                        vec_ps2[num_vectors]    = ps2;
                                        vec_joy0[num_vectors]   = joy0;
                                        vec_joy1[num_vectors]   = joy1;
                                        vec_swap[num_vectors]   = swap;
                                        vec_sel_kp[num_vectors] = sel_kp;
                                        vec_sel_js[num_vectors] = sel_js;
                                        vec_exp0[num_vectors]   = exp0;
                                        vec_exp1[num_vectors]   = exp1;
                                        num_vectors = num_vectors + 1;
                                end
                        end
                        $fclose(fd);
                        if (ok && num_vectors == 0) begin
                                $display("ERROR: stimulus file holds no test vectors");
                                ok = 1'b0;
                        end
                end
        endtask

        task automatic check_port(input logic [NAME_BITS-1:0] name, input int player,
                                  input logic [4:0] expected, input logic [4:0] actual,
                                  output logic ok);
                ok = 1'b1;
                if (actual !== expected) begin
                        $display("FAILED %0s player %0d: expected %05b, actual %05b",
                                 name, player, expected, actual);
                        ok = 1'b0;
                end
        endtask

        // ==================================================================
        // Main sequence
        // ==================================================================

        initial begin
                logic load_ok;
                logic ok0;
                logic ok1;
                clk_sys        = 1'b0;
                reset_i        = 1'b1;
                ps2_key_i      = '0;
                joy0_i         = '0;
                joy1_i         = '0;
                swap_i         = 1'b0;
                sel_keypad_n_i = '1;
                sel_joy_n_i    = '1;
                load_vectors(load_ok);
                cycle_limit = num_vectors + 20;
                if (!load_ok) begin
                        $display("Simulation finished: FAIL");
                        $finish;
                end else begin
                        repeat (4) @(posedge clk_sys);
                        @(negedge clk_sys);
                        reset_i = 1'b0;
                        for (int i = 0; i < num_vectors; i++) begin
                                ps2_key_i      = vec_ps2[i];
                                joy0_i         = vec_joy0[i];
                                joy1_i         = vec_joy1[i];
                                swap_i         = vec_swap[i];
                                sel_keypad_n_i = vec_sel_kp[i];
                                sel_joy_n_i    = vec_sel_js[i];
                                @(posedge clk_sys);
                                // Sample half a cycle later, away from the edge
                                @(negedge clk_sys);
                                check_port(vec_name[i], 0, vec_exp0[i], port_o[0], ok0);
                                check_port(vec_name[i], 1, vec_exp1[i], port_o[1], ok1);
                                if (ok0 && ok1) begin
                                        $display("ok      %0s", vec_name[i]);
                                        pass_count = pass_count + 1;
                                end else begin
                                        fail_count = fail_count + 1;
                                end
                        end
                        $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
                        if (fail_count == 0) begin
                                $display("Simulation finished: PASS");
                        end else begin
                                $display("Simulation finished: FAIL");
                        end
                        $finish;
                end
        end

endmodule

// File: cv_ctrl_top.f
hw/cv_ctrl_pkg.sv
hw/ps2_keypad_decode.sv
hw/pad_merge.sv
hw/keypad_port_encode.sv
hw/cv_ctrl_top.sv
bench/cv_ctrl_tb.sv

// File: hw/cv_ctrl_pkg.sv
// Two players with a fixed button map; joystick word bits 31..20 are ignored
package cv_ctrl_pkg;

        // ==================================================================
        // Sizes
        // ==================================================================

        localparam int NUM_PLAYERS = 2;

        // ==================================================================
        // Input words
        // ==================================================================

        // PS/2 key word from the host, toggle flips once per key event
        typedef struct packed {
                logic       toggle;
                logic       pressed;
                logic       extended;
                logic [7:0] code;
        } ps2_event_t;

        // Host joystick word, bit 0 is right
        typedef struct packed {
                logic [11:0] unused;
                logic        blue;
                logic        purple;
                logic [9:0]  digit;
                logic        number;
                logic        star;
                logic        fire2;
                logic        fire1;
                logic        up;
                logic        down;
                logic        left;
                logic        right;
        } joy_word_t;

        // ==================================================================
        // Per-player button vector and port lines
        // ==================================================================

        // Keypad priority runs digit 0 first, through to blue last
        typedef struct packed {
                logic [9:0] digit;
                logic       star;
                logic       number;
                logic       purple;
                logic       blue;
                logic       up;
                logic       down;
                logic       left;
                logic       right;
                logic       fire1;
                logic       fire2;
        } keypad_t;

        // Active low, ctrl[3] is port pin 1
        typedef struct packed {
                logic [3:0] ctrl;
                logic       p6;
        } port_lines_t;

        // Key codes the console reads back on ctrl while the keypad is selected
        typedef enum logic [3:0] {
                CV_KEY_0        = 4'b0011,
                CV_KEY_1        = 4'b1110,
                CV_KEY_2        = 4'b1101,
                CV_KEY_3        = 4'b0110,
                CV_KEY_4        = 4'b0001,
                CV_KEY_5        = 4'b1001,
                CV_KEY_6        = 4'b0111,
                CV_KEY_7        = 4'b1100,
                CV_KEY_8        = 4'b1000,
                CV_KEY_9        = 4'b1011,
                CV_KEY_ASTERISK = 4'b1010,
                CV_KEY_NUMBER   = 4'b0101,
                CV_KEY_PT       = 4'b0100,
                CV_KEY_BT       = 4'b0010,
                CV_KEY_NONE     = 4'b1111
        } cv_key_e;

        // Digit index to key code
        localparam cv_key_e CV_DIGIT_KEY [10] = '{
                CV_KEY_0, CV_KEY_1, CV_KEY_2, CV_KEY_3, CV_KEY_4,
                CV_KEY_5, CV_KEY_6, CV_KEY_7, CV_KEY_8, CV_KEY_9
        };

endpackage

// File: hw/cv_ctrl_top.sv
// Select inputs are active low, one bit per player; port lines answer them combinationally
module cv_ctrl_top (
        input  logic                                 clk_sys,
        input  logic                                 reset_i,
        input  cv_ctrl_pkg::ps2_event_t              ps2_key_i,
        input  cv_ctrl_pkg::joy_word_t               joy0_i,
        input  cv_ctrl_pkg::joy_word_t               joy1_i,
        input  logic                                 swap_i,
        input  logic [cv_ctrl_pkg::NUM_PLAYERS-1:0]  sel_keypad_n_i,
        input  logic [cv_ctrl_pkg::NUM_PLAYERS-1:0]  sel_joy_n_i,
        output cv_ctrl_pkg::port_lines_t             port_o [cv_ctrl_pkg::NUM_PLAYERS]
);
        import cv_ctrl_pkg::*;

        keypad_t kbd_pad;
        keypad_t pad [NUM_PLAYERS];

        // ==================================================================
        // Keyboard
        // ==================================================================

        ps2_keypad_decode ps2_keypad_decode_inst (
                .clk_sys   (clk_sys),
                .reset_i   (reset_i),
                .ps2_key_i (ps2_key_i),
                .kbd_pad_o (kbd_pad)
        );

        // ==================================================================
        // Joystick swap and keyboard merge
        // ==================================================================

        pad_merge pad_merge_inst (
                .joy0_i    (joy0_i),
                .joy1_i    (joy1_i),
                .swap_i    (swap_i),
                .kbd_pad_i (kbd_pad),
                .pad_o     (pad)
        );

        // ==================================================================
        // One port encoder per player
        // ==================================================================

        for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_player
                keypad_port_encode keypad_port_encode_inst (
                        .pad_i          (pad[p]),
                        .sel_keypad_n_i (sel_keypad_n_i[p]),
                        .sel_joy_n_i    (sel_joy_n_i[p]),
                        .port_o         (port_o[p])
                );
        end

endmodule

// File: hw/keypad_port_encode.sv
// Purely combinational; both selects low gives the AND of keypad and joystick lines
module keypad_port_encode (
        input  cv_ctrl_pkg::keypad_t      pad_i,
        input  logic                      sel_keypad_n_i,
        input  logic                      sel_joy_n_i,
        output cv_ctrl_pkg::port_lines_t  port_o
);
        import cv_ctrl_pkg::*;

        cv_key_e    key_code;
        logic [3:0] kp_ctrl;
        logic       kp_p6;
        logic [3:0] js_ctrl;
        logic       js_p6;

        // ==================================================================
        // Keypad priority encoder
        // ==================================================================

        // Walk from lowest to highest priority so the last hit wins
        always_comb begin
                key_code = CV_KEY_NONE;
                if (pad_i.blue) begin
                        key_code = CV_KEY_BT;
                end
                if (pad_i.purple) begin
                        key_code = CV_KEY_PT;
                end
                if (pad_i.number) begin
                        key_code = CV_KEY_NUMBER;
                end
                if (pad_i.star) begin
                        key_code = CV_KEY_ASTERISK;
                end
                for (int d = 9; d >= 0; d--) begin
                        if (pad_i.digit[d]) begin
                                key_code = CV_DIGIT_KEY[d];
                        end
                end
        end

        // Keypad side, fire 2 on p6
        assign kp_ctrl = sel_keypad_n_i ? 4'b1111 : key_code;
        assign kp_p6   = sel_keypad_n_i | ~pad_i.fire2;

        // ==================================================================
        // Joystick side
        // ==================================================================

        // Directions go out inverted, up on pin 1; fire 1 on p6
        assign js_ctrl = sel_joy_n_i ? 4'b1111 : ~{pad_i.up, pad_i.down, pad_i.left, pad_i.right};
        assign js_p6   = sel_joy_n_i | ~pad_i.fire1;

        // Open-collector style wired AND of both sides
        assign port_o.ctrl = kp_ctrl & js_ctrl;
        assign port_o.p6   = kp_p6 & js_p6;

endmodule

// File: hw/pad_merge.sv
// Both players see the keyboard; swap exchanges whole joystick words only
module pad_merge (
        input  cv_ctrl_pkg::joy_word_t joy0_i,
        input  cv_ctrl_pkg::joy_word_t joy1_i,
        input  logic                   swap_i,
        input  cv_ctrl_pkg::keypad_t   kbd_pad_i,
        output cv_ctrl_pkg::keypad_t   pad_o [cv_ctrl_pkg::NUM_PLAYERS]
);
        import cv_ctrl_pkg::*;

        joy_word_t joy_sel [NUM_PLAYERS];
        keypad_t   joy_pad [NUM_PLAYERS];

        // Player assignment
        assign joy_sel[0] = swap_i ? joy1_i : joy0_i;
        assign joy_sel[1] = swap_i ? joy0_i : joy1_i;

        // ==================================================================
        // Reorder into keypad fields and add the keyboard
        // ==================================================================

        always_comb begin
                for (int p = 0; p < NUM_PLAYERS; p++) begin
                        joy_pad[p].digit  = joy_sel[p].digit;
                        joy_pad[p].star   = joy_sel[p].star;
                        joy_pad[p].number = joy_sel[p].number;
                        joy_pad[p].purple = joy_sel[p].purple;
                        joy_pad[p].blue   = joy_sel[p].blue;
                        joy_pad[p].up     = joy_sel[p].up;
                        joy_pad[p].down   = joy_sel[p].down;
                        joy_pad[p].left   = joy_sel[p].left;
                        joy_pad[p].right  = joy_sel[p].right;
                        joy_pad[p].fire1  = joy_sel[p].fire1;
                        joy_pad[p].fire2  = joy_sel[p].fire2;

                        // Keyboard only ever sets digits, star and number
                        pad_o[p] = joy_pad[p] | kbd_pad_i;
                end
        end

endmodule

// File: hw/ps2_keypad_decode.sv
// Set 2 scan codes only, extended flag ignored; one event per clock, no back-pressure
module ps2_keypad_decode (
        input  logic                    clk_sys,
        input  logic                    reset_i,
        input  cv_ctrl_pkg::ps2_event_t ps2_key_i,
        output cv_ctrl_pkg::keypad_t    kbd_pad_o
);

        logic       toggle_q;
        logic       key_event;
        logic [9:0] btn_digit;
        logic       btn_star;
        logic       btn_minus;
        logic       btn_shift;

        // A new event is any change of the toggle bit
        assign key_event = ps2_key_i.toggle != toggle_q;

        // ==================================================================
        // Held button state
        // ==================================================================

        always_ff @(posedge clk_sys) begin
                toggle_q <= ps2_key_i.toggle;
                if (reset_i) begin
                        btn_digit <= '0;
                        btn_star  <= 1'b0;
                        btn_minus <= 1'b0;
                        btn_shift <= 1'b0;
                end else if (key_event) begin
                        case (ps2_key_i.code)
                                // Number row and numpad share each digit
                                8'h45, 8'h70: btn_digit[0] <= ps2_key_i.pressed;
                                8'h16, 8'h69: btn_digit[1] <= ps2_key_i.pressed;
                                8'h1E, 8'h72: btn_digit[2] <= ps2_key_i.pressed;
                                8'h26, 8'h7A: btn_digit[3] <= ps2_key_i.pressed;
                                8'h25, 8'h6B: btn_digit[4] <= ps2_key_i.pressed;
                                8'h2E, 8'h73: btn_digit[5] <= ps2_key_i.pressed;
                                8'h36, 8'h74: btn_digit[6] <= ps2_key_i.pressed;
                                8'h3D, 8'h6C: btn_digit[7] <= ps2_key_i.pressed;
                                8'h3E, 8'h75: btn_digit[8] <= ps2_key_i.pressed;
                                8'h46, 8'h7D: btn_digit[9] <= ps2_key_i.pressed;
                                // Numpad star
                                8'h7C: btn_star <= ps2_key_i.pressed;
                                // Numpad minus stands in for the number key
                                8'h7B: btn_minus <= ps2_key_i.pressed;
                                // Left and right shift
                                8'h12, 8'h59: btn_shift <= ps2_key_i.pressed;
                                default: ;
                        endcase
                end
        end

        // ==================================================================
        // Keypad view of the keyboard
        // ==================================================================

        always_comb begin
                kbd_pad_o       = '0;
                kbd_pad_o.digit = btn_digit;
                // Shift turns 8 into star and 3 into number, so the digit itself drops out
                kbd_pad_o.digit[8] = btn_digit[8] & ~btn_shift;
                kbd_pad_o.digit[3] = btn_digit[3] & ~btn_shift;
                kbd_pad_o.star     = btn_star | (btn_shift & btn_digit[8]);
                kbd_pad_o.number   = btn_minus | (btn_shift & btn_digit[3]);
        end

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile and run the controller testbench with Verilator, from the project root
rm -f sim.log
verilator --binary --timing --top-module cv_ctrl_tb -f cv_ctrl_top.f -o cv_ctrl_sim \
        > sim.log 2>&1 \
        && ./obj_dir/cv_ctrl_sim >> sim.log 2>&1 \
        || echo "Build or simulation error, see sim.log"
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0
